/* list.f */
+incdir+common
common/cache_pkg.sv
traffic_gen/cache_packet_generator.sv
design/port_arbiter.sv
design/block_memory.sv
design/cache_selftest_top.sv
sim/cache_selftest_sva.sv
sim/tb_cache_selftest.sv

/* Bender.yml */
package:
  name: cache_selftest

export_include_dirs:
  - common

sources:
  - common/cache_pkg.sv
  - traffic_gen/cache_packet_generator.sv
  - design/port_arbiter.sv
  - design/block_memory.sv
  - design/cache_selftest_top.sv
  - target: simulation
    files:
      - sim/cache_selftest_sva.sv
      - sim/tb_cache_selftest.sv

/* sim/tb_cache_selftest.sv */
`default_nettype none

`include "cache_consts.svh"

module tb_cache_selftest
    import cache_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int WAIT_LIMIT = 4 * `CACHE_TIMEOUT_CYCLES;

    logic       clk_in;
    logic       reset_in;
    logic       start;
    logic       check_mode;
    logic       host_req_valid;
    logic       host_req_ready;
    cache_pkt_t host_req;
    logic       host_rsp_valid;
    logic       host_rsp_ready;
    cache_pkt_t host_rsp;
    logic       busy;
    logic       done;
    logic       error;
    req_index_t fail_index;

    block_t model [0:`CACHE_MEM_DEPTH-1];   // expected memory contents
    integer seed;

    cache_selftest_top u_dut (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .start          (start),
        .check_mode     (check_mode),
        .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready),
        .host_req       (host_req),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp_ready (host_rsp_ready),
        .host_rsp       (host_rsp),
        .busy           (busy),
        .done           (done),
        .error          (error),
        .fail_index     (fail_index)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // request i carries the value i in every word
    function automatic block_t pattern_block(input int idx);
        return {4{idx[31:0]}};
    endfunction

    function automatic addr_t block_addr(input int idx);
        return `CACHE_BASE_ADDR + idx * `CACHE_BLOCK_BYTES;
    endfunction

    function automatic int model_index(input addr_t addr);
        return (addr / `CACHE_BLOCK_BYTES) % `CACHE_MEM_DEPTH;
    endfunction

    function automatic cache_pkt_t make_pkt(input logic is_write, input addr_t addr,
                                            input byte_mask_t mask, input block_t data);
        cache_pkt_t pkt;
        pkt.is_write  = is_write;
        pkt.cacheable = 1'b1;
        pkt.port      = '0;   // the arbiter stamps the real id
        pkt.addr      = addr;
        pkt.mask      = mask;
        pkt.data      = data;
        return pkt;
    endfunction

    task automatic apply_write(input addr_t addr, input byte_mask_t mask, input block_t data);
        for (int b = 0; b < `CACHE_BLOCK_BYTES; b++)
        begin
            if (mask[b])
                model[model_index(addr)][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    task automatic random_block(output block_t blk);
        for (int w = 0; w < 4; w++)
            blk[w*32 +: 32] = $random(seed);
    endtask

    ////////////////////
    // host port and pass control
    ////////////////////

    task automatic send_request(input cache_pkt_t pkt);
        int cycles;
        cycles = 0;
        @(negedge clk_in);
        host_req       = pkt;
        host_req_valid = 1'b1;
        @(posedge clk_in);
        while (!host_req_ready)
        begin
            cycles++;
            if (cycles > WAIT_LIMIT)
                report_failure("host request was not accepted in time");
            @(posedge clk_in);
        end
        @(negedge clk_in);
        host_req_valid = 1'b0;
    endtask

    task automatic host_write(input addr_t addr, input byte_mask_t mask, input block_t data);
        send_request(make_pkt(1'b1, addr, mask, data));
        apply_write(addr, mask, data);
    endtask

    // the response is held back for hold cycles after it shows up
    task automatic host_read(input addr_t addr, input int hold, output block_t data);
        int cycles;
        cycles = 0;
        send_request(make_pkt(1'b0, addr, '0, '0));
        while (!host_rsp_valid)
        begin
            cycles++;
            if (cycles > WAIT_LIMIT)
                report_failure("host read response did not arrive in time");
            @(negedge clk_in);
        end
        repeat (hold) @(negedge clk_in);
        data = host_rsp.data;
        assert (host_rsp.addr == addr)
        else report_failure($sformatf("error: host_rsp.addr is %h, expected %h",
                                      host_rsp.addr, addr));
        assert (host_rsp.port == port_id_t'(2))
        else report_failure($sformatf("error: host_rsp.port is %h, expected %h",
                                      host_rsp.port, 2'h2));
        host_rsp_ready = 1'b1;
        @(negedge clk_in);
        host_rsp_ready = 1'b0;
    endtask

    task automatic check_block(input int idx, input int hold);
        block_t data;
        host_read(block_addr(idx), hold, data);
        assert (data === model[model_index(block_addr(idx))])
        else report_failure($sformatf("error: host_rsp.data at %h is %h, expected %h",
                                      block_addr(idx), data,
                                      model[model_index(block_addr(idx))]));
    endtask

    task automatic run_pass(input logic mode, output logic err, output req_index_t fidx);
        int cycles;
        cycles = 0;
        @(negedge clk_in);
        check_mode = mode;
        start      = 1'b1;
        @(negedge clk_in);
        start = 1'b0;
        assert (busy) else report_failure("generator did not become busy after start");
        while (!done)
        begin
            cycles++;
            if (cycles > WAIT_LIMIT)
                report_failure("self-test pass did not signal done in time");
            @(negedge clk_in);
        end
        err  = error;
        fidx = fail_index;
        if (!mode)
        begin
            for (int i = 0; i < `CACHE_NUM_REQUEST; i++)
                apply_write(block_addr(i), '1, pattern_block(i));
        end
    endtask

    task automatic expect_error_flag(input logic err, input logic expected);
        assert (err == expected)
        else report_failure($sformatf("error: error is %h, expected %h", err, expected));
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic check_reset_and_write();
        logic       err;
        req_index_t fidx;
        assert (!busy && !done && !error && !host_rsp_valid)
        else report_failure("a status output or host response valid is high after reset");
        run_pass(1'b0, err, fidx);
        expect_error_flag(err, 1'b0);
    endtask

    task automatic check_readback();
        for (int i = 0; i < `CACHE_NUM_REQUEST; i++)
            check_block(i, 0);
    endtask

    task automatic check_clean_pass();
        logic       err;
        req_index_t fidx;
        run_pass(1'b1, err, fidx);
        expect_error_flag(err, 1'b0);
    endtask

    task automatic check_altered_block();
        block_t     data;
        logic       err;
        req_index_t fidx;
        random_block(data);
        data[23:16] = ~model[5][23:16];   // byte 2 is in the mask so block 5 surely differs
        host_write(block_addr(5), 16'h0f3c, data);
        check_block(5, 0);
        run_pass(1'b1, err, fidx);
        expect_error_flag(err, 1'b1);
        assert (fidx == req_index_t'(5))
        else report_failure($sformatf("error: fail_index is %h, expected %h", fidx, 8'h05));
    endtask

    task automatic check_pass_under_host_traffic();
        block_t     data;
        logic       err;
        req_index_t fidx;
        for (int i = 32; i < 38; i++)
        begin
            random_block(data);
            host_write(block_addr(i), '1, data);
        end
        fork
            run_pass(1'b1, err, fidx);
            begin
                for (int i = 32; i < 38; i++)
                    check_block(i, 2 + ($unsigned($random(seed)) % 4));
            end
        join
        // block 5 is still altered here
        expect_error_flag(err, 1'b1);
        assert (fidx == req_index_t'(5))
        else report_failure($sformatf("error: fail_index is %h, expected %h", fidx, 8'h05));
    endtask

    task automatic check_rewrite_restores();
        logic       err;
        req_index_t fidx;
        run_pass(1'b0, err, fidx);
        expect_error_flag(err, 1'b0);
        check_block(5, 1);
        run_pass(1'b1, err, fidx);
        expect_error_flag(err, 1'b0);
    endtask

    initial
    begin
        seed           = 32'h6683_b49e;
        reset_in       = 1'b1;
        start          = 1'b0;
        check_mode     = 1'b0;
        host_req_valid = 1'b0;
        host_req       = '0;
        host_rsp_ready = 1'b0;
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        reset_in = 1'b0;

        check_reset_and_write();
        check_readback();
        check_clean_pass();
        check_altered_block();
        check_pass_under_host_traffic();
        check_rewrite_restores();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cache_selftest_sva.sv */
`default_nettype none

`include "cache_consts.svh"

module cache_selftest_sva
    import cache_pkg::*;
(
    input wire                         clk_in,
    input wire                         reset_in,
    input wire                         out_valid,
    input wire                         out_ready,
    input wire cache_pkt_t             out_pkt,
    input wire                         accept,
    input wire [`CACHE_NUM_PORTS-1:0]  rsp_valid_vec
);

    // a stalled output keeps valid and its packet
    a_stall_hold: assert property (
        @(posedge clk_in) disable iff (reset_in)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt)
    ) else $error("stalled valid dropped or its packet changed");

    a_one_destination: assert property (
        @(posedge clk_in) disable iff (reset_in)
        $onehot0(rsp_valid_vec)
    ) else $error("more than one destination response valid");

    a_accept_gives_valid: assert property (
        @(posedge clk_in) disable iff (reset_in)
        accept |=> out_valid
    ) else $error("accepted request did not produce a valid output");   // one cycle later

endmodule

bind port_arbiter cache_selftest_sva u_arb_sva (
    .clk_in        (clk_in),
    .reset_in      (reset_in),
    .out_valid     (mem_req_valid),
    .out_ready     (mem_req_ready),
    .out_pkt       (mem_req),
    .accept        (load_en && grant_valid),
    .rsp_valid_vec (dst_rsp_valid)
);

bind block_memory cache_selftest_sva u_mem_sva (
    .clk_in        (clk_in),
    .reset_in      (reset_in),
    .out_valid     (rsp_valid),
    .out_ready     (rsp_ready),
    .out_pkt       (rsp),
    .accept        (req_fire && !req.is_write),
    .rsp_valid_vec ({{(`CACHE_NUM_PORTS-1){1'b0}}, rsp_valid})
);

`default_nettype wire

/* design/cache_selftest_top.sv */
`default_nettype none

`include "cache_consts.svh"

module cache_selftest_top
    import cache_pkg::*;
(
    input  wire             clk_in,
    input  wire             reset_in,
    input  wire             start,
    input  wire             check_mode,

    input  wire             host_req_valid,
    output logic            host_req_ready,
    input  wire cache_pkt_t host_req,

    output logic            host_rsp_valid,
    input  wire             host_rsp_ready,
    output cache_pkt_t      host_rsp,

    output logic            busy,
    output logic            done,
    output logic            error,
    output req_index_t      fail_index
);

    logic       wr_req_valid;
    logic       wr_req_ready;
    cache_pkt_t wr_req;
    logic       rd_req_valid;
    logic       rd_req_ready;
    cache_pkt_t rd_req;

    logic       gen_rsp_valid;
    logic       gen_rsp_ready;
    logic       wr_way_rsp_valid;
    logic       rd_way_rsp_valid;
    cache_pkt_t arb_rsp;

    logic       mem_req_valid;
    logic       mem_req_ready;
    cache_pkt_t mem_req;
    logic       mem_rsp_valid;
    logic       mem_rsp_ready;
    cache_pkt_t mem_rsp;

    // both generator ways share its single return channel
    assign gen_rsp_valid = wr_way_rsp_valid || rd_way_rsp_valid;
    assign host_rsp      = arb_rsp;

    cache_packet_generator u_generator (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .start        (start),
        .check_mode   (check_mode),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready),
        .wr_req       (wr_req),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .rd_req       (rd_req),
        .rsp_valid    (gen_rsp_valid),
        .rsp_ready    (gen_rsp_ready),
        .rsp          (arb_rsp),
        .busy         (busy),
        .done         (done),
        .error        (error),
        .fail_index   (fail_index)
    );

    port_arbiter u_arbiter (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .src_valid     ({host_req_valid, rd_req_valid, wr_req_valid}),
        .src_ready     ({host_req_ready, rd_req_ready, wr_req_ready}),
        .src_req       ({host_req, rd_req, wr_req}),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp       (mem_rsp),
        .dst_rsp_valid ({host_rsp_valid, rd_way_rsp_valid, wr_way_rsp_valid}),
        .dst_rsp_ready ({host_rsp_ready, gen_rsp_ready, gen_rsp_ready}),
        .dst_rsp       (arb_rsp)
    );

    block_memory #(
        .DEPTH (`CACHE_MEM_DEPTH)
    ) u_memory (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .req       (mem_req),
        .rsp_valid (mem_rsp_valid),
        .rsp_ready (mem_rsp_ready),
        .rsp       (mem_rsp)
    );

endmodule

`default_nettype wire

/* design/block_memory.sv */
`default_nettype none

`include "cache_consts.svh"

module block_memory
    import cache_pkg::*;
#(
    parameter int DEPTH = `CACHE_MEM_DEPTH
)
(
    input  wire             clk_in,
    input  wire             reset_in,

    input  wire             req_valid,
    output logic            req_ready,
    input  wire cache_pkt_t req,

    output logic            rsp_valid,
    input  wire             rsp_ready,
    output cache_pkt_t      rsp
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    block_t             mem_array [0:DEPTH-1];
    addr_t              block_num;
    logic [IDX_W-1:0]   mem_idx;
    logic               req_fire;

    assign block_num = req.addr / `CACHE_BLOCK_BYTES;
    assign mem_idx   = IDX_W'(block_num % DEPTH);   // addresses wrap around the array

    // a held response blocks every new request, writes included
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk_in)
    begin
        if (req_fire && req.is_write)
        begin
            for (int b = 0; b < `CACHE_BLOCK_BYTES; b++)
            begin
                if (req.mask[b])
                    mem_array[mem_idx][b*8 +: 8] <= req.data[b*8 +: 8];
            end
        end
    end

    ////////////////////
    // read response
    ////////////////////

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
            rsp_valid <= 1'b0;
        else if (req_fire && !req.is_write)
            rsp_valid <= 1'b1;
        else if (rsp_ready)
            rsp_valid <= 1'b0;   // taken, nothing new behind it
    end

    always_ff @(posedge clk_in)
    begin
        if (req_fire && !req.is_write)
        begin
            rsp.is_write  <= 1'b0;
            rsp.cacheable <= req.cacheable;
            rsp.port      <= req.port;   // lets the arbiter route it back
            rsp.addr      <= req.addr;
            rsp.mask      <= '0;
            rsp.data      <= mem_array[mem_idx];
        end
    end

endmodule

`default_nettype wire

/* design/port_arbiter.sv */
`default_nettype none

`include "cache_consts.svh"

module port_arbiter
    import cache_pkg::*;
(
    input  wire                               clk_in,
    input  wire                               reset_in,

    input  wire  [`CACHE_NUM_PORTS-1:0]       src_valid,
    output logic [`CACHE_NUM_PORTS-1:0]       src_ready,
    input  wire cache_pkt_t [`CACHE_NUM_PORTS-1:0] src_req,

    output logic                              mem_req_valid,
    input  wire                               mem_req_ready,
    output cache_pkt_t                        mem_req,

    input  wire                               mem_rsp_valid,
    output logic                              mem_rsp_ready,
    input  wire cache_pkt_t                   mem_rsp,

    output logic [`CACHE_NUM_PORTS-1:0]       dst_rsp_valid,
    input  wire  [`CACHE_NUM_PORTS-1:0]       dst_rsp_ready,
    output cache_pkt_t                        dst_rsp
);

    localparam int NUM_SRC = `CACHE_NUM_PORTS;

    port_id_t last_grant;
    port_id_t grant_idx;
    logic     grant_valid;
    logic     load_en;

    ////////////////////
    // round-robin grant
    ////////////////////

    // the search starts at the source after the one last granted
    always_comb
    begin
        int cand;
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        for (int off = 1; off <= NUM_SRC; off++)
        begin
            cand = (int'(last_grant) + off) % NUM_SRC;
            if (!grant_valid && src_valid[cand])
            begin
                grant_valid = 1'b1;
                grant_idx   = port_id_t'(cand);
            end
        end
    end

    assign load_en = !mem_req_valid || mem_req_ready;   // register empty or draining

    always_comb
    begin
        for (int i = 0; i < NUM_SRC; i++)
            src_ready[i] = load_en && grant_valid && (grant_idx == port_id_t'(i));
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            mem_req_valid <= 1'b0;
            last_grant    <= port_id_t'(NUM_SRC - 1);   // source 0 goes first
        end
        else if (load_en)
        begin
            mem_req_valid <= grant_valid;
            if (grant_valid)
                last_grant <= grant_idx;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load_en && grant_valid)
        begin
            mem_req      <= src_req[grant_idx];
            mem_req.port <= grant_idx;   // sources never send their own id
        end
    end

    ////////////////////
    // response steering
    ////////////////////

    assign dst_rsp = mem_rsp;

    always_comb
    begin
        mem_rsp_ready = 1'b0;
        for (int i = 0; i < NUM_SRC; i++)
        begin
            dst_rsp_valid[i] = mem_rsp_valid && (mem_rsp.port == port_id_t'(i));
            if (mem_rsp.port == port_id_t'(i))
                mem_rsp_ready = dst_rsp_ready[i];
        end
    end

endmodule

`default_nettype wire

/* traffic_gen/cache_packet_generator.sv */
`default_nettype none

`include "cache_consts.svh"

module cache_packet_generator
    import cache_pkg::*;
#(
    parameter int NUM_REQUEST    = `CACHE_NUM_REQUEST,
    parameter int TIMEOUT_CYCLES = `CACHE_TIMEOUT_CYCLES
)
(
    input  wire        clk_in,
    input  wire        reset_in,
    input  wire        start,
    input  wire        check_mode,   // low runs the write pass, high the check pass

    output logic       wr_req_valid,
    input  wire        wr_req_ready,
    output cache_pkt_t wr_req,

    output logic       rd_req_valid,
    input  wire        rd_req_ready,
    output cache_pkt_t rd_req,

    input  wire        rsp_valid,
    output logic       rsp_ready,
    input  wire cache_pkt_t rsp,

    output logic       busy,
    output logic       done,
    output logic       error,
    output req_index_t fail_index
);

    localparam req_index_t REQ_COUNT  = req_index_t'(NUM_REQUEST);
    localparam req_index_t LAST_INDEX = req_index_t'(NUM_REQUEST - 1);
    localparam int         STALL_W    = $clog2(TIMEOUT_CYCLES + 1);

    gen_state_t         state;
    req_index_t         issue_idx;    // next request to send
    req_index_t         expect_idx;   // next response to check
    logic [STALL_W-1:0] stall_cnt;

    logic wr_fire;
    logic rd_fire;
    logic rsp_fire;
    logic progress;
    logic pending;
    logic timed_out;
    logic rsp_mismatch;

    ////////////////////
    // pattern rule
    ////////////////////

    function automatic block_t pattern_data(input req_index_t idx);
        return {(`CACHE_BLOCK_BITS / `CACHE_WORD_BITS){`CACHE_WORD_BITS'(idx)}};
    endfunction

    function automatic cache_pkt_t pattern_pkt(input req_index_t idx, input logic is_write);
        cache_pkt_t pkt;
        pkt.is_write  = is_write;
        pkt.cacheable = 1'b1;
        pkt.port      = '0;
        pkt.addr      = addr_t'(`CACHE_BASE_ADDR) + addr_t'(idx) * `CACHE_BLOCK_BYTES;
        pkt.mask      = is_write ? '1 : '0;
        pkt.data      = is_write ? pattern_data(idx) : '0;
        return pkt;
    endfunction

    ////////////////////
    // request and response handshakes
    ////////////////////

    // packets follow issue_idx, which only moves on a transfer
    assign wr_req       = pattern_pkt(issue_idx, 1'b1);
    assign rd_req       = pattern_pkt(issue_idx, 1'b0);
    assign wr_req_valid = (state == WRITE_PASS) && (issue_idx != REQ_COUNT);
    assign rd_req_valid = (state == READ_PASS) && (issue_idx != REQ_COUNT);
    assign rsp_ready    = (state == READ_PASS);

    assign wr_fire      = wr_req_valid && wr_req_ready;
    assign rd_fire      = rd_req_valid && rd_req_ready;
    assign rsp_fire     = rsp_valid && rsp_ready;
    assign progress     = wr_fire || rd_fire || rsp_fire;
    assign pending      = (state == WRITE_PASS) || (state == READ_PASS);
    assign timed_out    = (stall_cnt == STALL_W'(TIMEOUT_CYCLES)) && !progress;
    assign rsp_mismatch = (rsp.data != pattern_data(expect_idx));

    assign busy = (state != IDLE);
    assign done = (state == FINISH);   // FINISH lasts exactly one cycle

    // counts cycles without any transfer while a pass is running
    always_ff @(posedge clk_in)
    begin
        if (reset_in || !pending || progress)
            stall_cnt <= '0;
        else if (stall_cnt != STALL_W'(TIMEOUT_CYCLES))
            stall_cnt <= stall_cnt + 1'b1;
    end

    ////////////////////
    // pass control
    ////////////////////

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state      <= IDLE;
            issue_idx  <= '0;
            expect_idx <= '0;
            error      <= 1'b0;
            fail_index <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state      <= check_mode ? READ_PASS : WRITE_PASS;
                        issue_idx  <= '0;
                        expect_idx <= '0;
                        error      <= 1'b0;
                        fail_index <= '0;
                    end
                end
                WRITE_PASS:
                begin
                    if (wr_fire)
                    begin
                        issue_idx <= issue_idx + 1'b1;
                        if (issue_idx == LAST_INDEX)
                            state <= FINISH;
                    end
                    else if (timed_out)
                    begin
                        error      <= 1'b1;
                        fail_index <= issue_idx;
                        state      <= FINISH;
                    end
                end
                READ_PASS:
                begin
                    if (rd_fire)
                        issue_idx <= issue_idx + 1'b1;
                    if (rsp_fire)
                    begin
                        expect_idx <= expect_idx + 1'b1;
                        if (rsp_mismatch && !error)
                        begin
                            error      <= 1'b1;   // first mismatch wins
                            fail_index <= expect_idx;
                        end
                        // reads already in flight still drain before done
                        if (expect_idx == LAST_INDEX)
                            state <= FINISH;
                    end
                    else if (timed_out)
                    begin
                        error <= 1'b1;
                        if (!error)
                            fail_index <= expect_idx;
                        state <= FINISH;
                    end
                end
                FINISH:
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/cache_pkg.sv */
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    ////////////////////
    // width types
    ////////////////////

    typedef logic [`CACHE_ADDR_WIDTH-1:0]      addr_t;
    typedef logic [`CACHE_BLOCK_BITS-1:0]      block_t;
    typedef logic [`CACHE_BLOCK_BYTES-1:0]     byte_mask_t;
    typedef logic [`CACHE_PORT_ID_WIDTH-1:0]   port_id_t;
    typedef logic [`CACHE_REQ_INDEX_WIDTH-1:0] req_index_t;

    ////////////////////
    // cache packet
    ////////////////////

    // validity travels beside the packet as its own signal
    typedef struct packed {
        logic       is_write;
        logic       cacheable;   // carried but not acted on
        port_id_t   port;        // stamped by the arbiter
        addr_t      addr;
        byte_mask_t mask;
        block_t     data;
    } cache_pkt_t;

    // generator FSM
    typedef enum logic [1:0] {
        IDLE,
        WRITE_PASS,
        READ_PASS,
        FINISH
    } gen_state_t;

endpackage

`default_nettype wire

/* common/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

////////////////////
// packet field widths
////////////////////

`define CACHE_ADDR_WIDTH        32
`define CACHE_BLOCK_BITS        128
`define CACHE_BLOCK_BYTES       16
`define CACHE_WORD_BITS         32
`define CACHE_PORT_ID_WIDTH     2
`define CACHE_REQ_INDEX_WIDTH   8
`define CACHE_NUM_PORTS         3

////////////////////
// memory and self-test defaults
////////////////////

`define CACHE_MEM_DEPTH         64
`define CACHE_BASE_ADDR         32'h0000_1000

// request count must fit in the request index type
`define CACHE_NUM_REQUEST       16
`define CACHE_TIMEOUT_CYCLES    1000

`endif
